/* hdl/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`default_nettype none

// cache geometry
`define ADDR_BITS       32
`define WORD_BITS       32
`define WORDS_PER_LINE  4
`define L2_SETS         16
`define L2_WAYS         2

// derived field widths
`define SET_BITS        4
`define WAY_BITS        1
`define W_OFF_BITS      2
`define B_OFF_BITS      2
`define TAG_BITS        (`ADDR_BITS - `SET_BITS - `W_OFF_BITS - `B_OFF_BITS)

`default_nettype wire

`endif

/* hdl/cache_pkg.sv */
`include "cache_config.svh"
`default_nettype none

package cache_pkg;

    typedef logic [`ADDR_BITS-1:0]                 addr_t;
    typedef logic [`TAG_BITS+`SET_BITS-1:0]        line_addr_t;
    typedef logic [`TAG_BITS-1:0]                  l2_tag_t;
    typedef logic [`SET_BITS-1:0]                  l2_set_t;
    typedef logic [`WAY_BITS-1:0]                  l2_way_t;
    typedef logic [`W_OFF_BITS-1:0]                word_offset_t;
    typedef logic [`B_OFF_BITS-1:0]                byte_offset_t;
    typedef logic [`WORD_BITS-1:0]                 word_t;
    typedef logic [`WORDS_PER_LINE*`WORD_BITS-1:0] line_t;

    typedef enum logic [1:0] {
        INVALID = 2'd0,
        VALID   = 2'd1,
        DIRTY   = 2'd2
    } state_t;

    // address fields, msb first
    typedef struct packed {
        l2_tag_t      tag;
        l2_set_t      set;
        word_offset_t w_off;
        byte_offset_t b_off;
    } l2_addr_br_t;

    typedef union packed {
        addr_t       addr;
        l2_addr_br_t br;
    } l2_addr_u;

endpackage

`default_nettype wire

/* hdl/cache_msg_pkg.sv */
`default_nettype none

package cache_msg_pkg;

    import cache_pkg::*;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } cpu_msg_t;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } hsize_t;

    // GET requests a fill, PUT writes a dirty line back
    typedef enum logic {
        GET = 1'b0,
        PUT = 1'b1
    } coh_msg_t;

    typedef struct packed {
        cpu_msg_t cpu_msg;
        hsize_t   hsize;
        addr_t    addr;
        word_t    word;
    } l2_cpu_req_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        line_addr_t line_addr;
        line_t      line;
    } l2_req_out_t;

    typedef struct packed {
        line_addr_t line_addr;
        line_t      line;
    } l2_rsp_in_t;

    typedef struct packed {
        word_t word;
    } l2_rd_rsp_t;

endpackage

`default_nettype wire

/* hdl/l2_lookup.sv */
`include "cache_config.svh"
`default_nettype none

module l2_lookup (
    input  wire cache_pkg::l2_tag_t                req_tag_i,
    input  wire cache_pkg::l2_tag_t [`L2_WAYS-1:0] tags_i,
    input  wire cache_pkg::state_t  [`L2_WAYS-1:0] states_i,
    input  wire cache_pkg::l2_way_t                evict_way_i,
    output logic                                   tag_hit_o,
    output cache_pkg::l2_way_t                     way_hit_o,
    output cache_pkg::l2_way_t                     victim_way_o
);
    import cache_pkg::*;

    logic empty_found;

    always_comb begin
        tag_hit_o    = 1'b0;
        way_hit_o    = '0;
        empty_found  = 1'b0;
        victim_way_o = evict_way_i;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (states_i[w] != INVALID && tags_i[w] == req_tag_i) begin
                tag_hit_o = 1'b1;
                way_hit_o = l2_way_t'(w);
            end
            // lowest invalid way wins over the evict pointer
            if (states_i[w] == INVALID && !empty_found) begin
                empty_found  = 1'b1;
                victim_way_o = l2_way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/l2_localmem.sv */
`include "cache_config.svh"
`default_nettype none

module l2_localmem (
    input  wire logic                              clk,
    input  wire logic                              rst_i,
    input  wire cache_pkg::l2_set_t                set_i,
    input  wire logic                              wr_en_i,
    input  wire cache_pkg::l2_way_t                wr_way_i,
    input  wire cache_pkg::l2_tag_t                wr_tag_i,
    input  wire cache_pkg::state_t                 wr_state_i,
    input  wire cache_pkg::line_t                  wr_line_i,
    input  wire logic                              incr_evict_i,
    output cache_pkg::l2_tag_t [`L2_WAYS-1:0]      rd_tags_o,
    output cache_pkg::state_t  [`L2_WAYS-1:0]      rd_states_o,
    output cache_pkg::line_t   [`L2_WAYS-1:0]      rd_lines_o,
    output cache_pkg::l2_way_t                     evict_way_o
);
    import cache_pkg::*;

    l2_tag_t tags      [`L2_SETS][`L2_WAYS];
    line_t   lines     [`L2_SETS][`L2_WAYS];
    state_t  states    [`L2_SETS][`L2_WAYS];
    l2_way_t evict_ptr [`L2_SETS];

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags[set_i][wr_way_i]  <= wr_tag_i;
            lines[set_i][wr_way_i] <= wr_line_i;
        end
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd_tags_o[w]  <= tags[set_i][w];
            rd_lines_o[w] <= lines[set_i][w];
        end
    end

    // line states and round-robin pointers
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                for (int w = 0; w < `L2_WAYS; w++) begin
                    states[s][w] <= INVALID;
                end
                evict_ptr[s] <= '0;
            end
            for (int w = 0; w < `L2_WAYS; w++) begin
                rd_states_o[w] <= INVALID;
            end
            evict_way_o <= '0;
        end else begin
            if (wr_en_i) begin
                states[set_i][wr_way_i] <= wr_state_i;
            end
            if (incr_evict_i) begin
                evict_ptr[set_i] <= l2_way_t'(evict_ptr[set_i] + 1'b1);
            end
            for (int w = 0; w < `L2_WAYS; w++) begin
                rd_states_o[w] <= states[set_i][w];
            end
            evict_way_o <= evict_ptr[set_i];
        end
    end

endmodule

`default_nettype wire

/* hdl/l2_write_word.sv */
`include "cache_config.svh"
`default_nettype none

module l2_write_word (
    input  wire cache_pkg::line_t        line_i,
    input  wire cache_pkg::word_offset_t w_off_i,
    input  wire cache_pkg::byte_offset_t b_off_i,
    input  wire cache_msg_pkg::hsize_t   hsize_i,
    input  wire cache_pkg::word_t        word_i,
    output cache_pkg::line_t             line_o
);
    import cache_pkg::*;
    import cache_msg_pkg::*;

    int unsigned base;

    always_comb begin
        line_o = line_i;
        base   = int'(w_off_i) * `WORD_BITS;
        case (hsize_i)
            BYTE: line_o[base + 8*int'(b_off_i) +: 8] = word_i[7:0];
            // halfword picked by the upper byte offset bit
            HALF: line_o[base + 16*int'(b_off_i[1]) +: 16] = word_i[15:0];
            default: line_o[base +: `WORD_BITS] = word_i;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/l2_fsm.sv */
`include "cache_config.svh"
`default_nettype none

module l2_fsm (
    input  wire logic                         clk,
    input  wire logic                         rst_i,
    input  wire logic                         cpu_req_valid_i,
    input  wire cache_msg_pkg::l2_cpu_req_t   cpu_req_i,
    output logic                              cpu_req_ready_o,
    output logic                              req_out_valid_o,
    output cache_msg_pkg::l2_req_out_t        req_out_o,
    input  wire logic                         req_out_ready_i,
    input  wire logic                         rsp_in_valid_i,
    input  wire cache_msg_pkg::l2_rsp_in_t    rsp_in_i,
    output logic                              rsp_in_ready_o,
    output logic                              rd_rsp_valid_o,
    output cache_msg_pkg::l2_rd_rsp_t         rd_rsp_o,
    input  wire logic                         rd_rsp_ready_i,
    input  wire logic                         tag_hit_i,
    input  wire cache_pkg::l2_way_t           way_hit_i,
    input  wire cache_pkg::l2_way_t           victim_way_i,
    input  wire cache_pkg::l2_tag_t [`L2_WAYS-1:0] rd_tags_i,
    input  wire cache_pkg::state_t  [`L2_WAYS-1:0] rd_states_i,
    input  wire cache_pkg::line_t   [`L2_WAYS-1:0] rd_lines_i,
    input  wire cache_pkg::line_t             merged_line_i,
    output cache_pkg::line_t                  merge_line_o,
    output cache_pkg::word_offset_t           merge_w_off_o,
    output cache_pkg::byte_offset_t           merge_b_off_o,
    output cache_msg_pkg::hsize_t             merge_hsize_o,
    output cache_pkg::word_t                  merge_word_o,
    output cache_pkg::l2_tag_t                req_tag_o,
    output cache_pkg::l2_set_t                set_o,
    output logic                              wr_en_o,
    output cache_pkg::l2_way_t                wr_way_o,
    output cache_pkg::l2_tag_t                wr_tag_o,
    output cache_pkg::state_t                 wr_state_o,
    output cache_pkg::line_t                  wr_line_o,
    output logic                              incr_evict_o
);
    import cache_pkg::*;
    import cache_msg_pkg::*;

    typedef enum logic [2:0] {IDLE, LOOKUP, DECIDE, WB, GET, FILL, RESP} fsm_state_t;

    fsm_state_t  state_q;
    fsm_state_t  state_d;
    l2_cpu_req_t req_q;
    l2_addr_u    req_addr;
    l2_way_t     victim_way_q;
    l2_tag_t     victim_tag_q;
    line_t       victim_line_q;
    word_t       rd_word_q;
    logic        load_word;
    logic        is_write;

    assign req_addr.addr = req_q.addr;
    assign is_write      = (req_q.cpu_msg == WRITE);

    assign req_tag_o     = req_addr.br.tag;
    assign set_o         = req_addr.br.set;
    assign merge_w_off_o = req_addr.br.w_off;
    assign merge_b_off_o = req_addr.br.b_off;
    assign merge_hsize_o = req_q.hsize;
    assign merge_word_o  = req_q.word;

    // fill data while filling, hit line otherwise
    assign merge_line_o = (state_q == FILL) ? rsp_in_i.line : rd_lines_i[way_hit_i];

    assign wr_way_o   = (state_q == FILL) ? victim_way_q : way_hit_i;
    assign wr_tag_o   = req_addr.br.tag;
    assign wr_state_o = is_write ? DIRTY : VALID;
    assign wr_line_o  = is_write ? merged_line_i : merge_line_o;

    assign cpu_req_ready_o = (state_q == IDLE);
    assign rsp_in_ready_o  = (state_q == FILL);
    assign rd_rsp_valid_o  = (state_q == RESP);
    assign rd_rsp_o.word   = rd_word_q;

    assign req_out_valid_o     = (state_q == WB) || (state_q == GET);
    assign req_out_o.coh_msg   = (state_q == WB) ? cache_msg_pkg::PUT : cache_msg_pkg::GET;
    assign req_out_o.line_addr = (state_q == WB) ? {victim_tag_q, req_addr.br.set}
                                                 : {req_addr.br.tag, req_addr.br.set};
    assign req_out_o.line      = victim_line_q;

    always_comb begin
        state_d      = state_q;
        wr_en_o      = 1'b0;
        incr_evict_o = 1'b0;
        load_word    = 1'b0;
        case (state_q)
            IDLE: begin
                if (cpu_req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: state_d = DECIDE;
            DECIDE: begin
                if (tag_hit_i && is_write) begin
                    wr_en_o = 1'b1;
                    state_d = IDLE;
                end else if (tag_hit_i) begin
                    load_word = 1'b1;
                    state_d   = RESP;
                end else if (rd_states_i[victim_way_i] == DIRTY) begin
                    state_d = WB;
                end else begin
                    state_d = GET;
                end
            end
            WB: begin
                if (req_out_ready_i) begin
                    state_d = GET;
                end
            end
            GET: begin
                if (req_out_ready_i) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (rsp_in_valid_i) begin
                    wr_en_o      = 1'b1;
                    incr_evict_o = 1'b1;
                    load_word    = !is_write;
                    state_d      = is_write ? IDLE : RESP;
                end
            end
            RESP: begin
                if (rd_rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid_i && cpu_req_ready_o) begin
            req_q <= cpu_req_i;
        end
        // victim is captured as the arrays are read
        if (state_q == DECIDE) begin
            victim_way_q  <= victim_way_i;
            victim_tag_q  <= rd_tags_i[victim_way_i];
            victim_line_q <= rd_lines_i[victim_way_i];
        end
        if (load_word) begin
            rd_word_q <= merge_line_o[req_addr.br.w_off*`WORD_BITS +: `WORD_BITS];
        end
    end

endmodule

`default_nettype wire

/* hdl/l2_core.sv */
`include "cache_config.svh"
`default_nettype none

module l2_core (
    input  wire logic                       clk,
    input  wire logic                       rst_i,
    input  wire logic                       cpu_req_valid_i,
    input  wire cache_msg_pkg::l2_cpu_req_t cpu_req_i,
    output logic                            cpu_req_ready_o,
    output logic                            req_out_valid_o,
    output cache_msg_pkg::l2_req_out_t      req_out_o,
    input  wire logic                       req_out_ready_i,
    input  wire logic                       rsp_in_valid_i,
    input  wire cache_msg_pkg::l2_rsp_in_t  rsp_in_i,
    output logic                            rsp_in_ready_o,
    output logic                            rd_rsp_valid_o,
    output cache_msg_pkg::l2_rd_rsp_t       rd_rsp_o,
    input  wire logic                       rd_rsp_ready_i
);
    import cache_pkg::*;
    import cache_msg_pkg::*;

    logic                      tag_hit;
    l2_way_t                   way_hit;
    l2_way_t                   victim_way;
    l2_way_t                   evict_way;
    l2_tag_t [`L2_WAYS-1:0]    rd_tags;
    state_t  [`L2_WAYS-1:0]    rd_states;
    line_t   [`L2_WAYS-1:0]    rd_lines;

    line_t                     merge_line;
    line_t                     merged_line;
    word_offset_t              merge_w_off;
    byte_offset_t              merge_b_off;
    hsize_t                    merge_hsize;
    word_t                     merge_word;

    l2_tag_t                   req_tag;
    l2_set_t                   set;
    logic                      wr_en;
    l2_way_t                   wr_way;
    l2_tag_t                   wr_tag;
    state_t                    wr_state;
    line_t                     wr_line;
    logic                      incr_evict;

    l2_fsm u_fsm (
        .clk, .rst_i,
        .cpu_req_valid_i, .cpu_req_i, .cpu_req_ready_o,
        .req_out_valid_o, .req_out_o, .req_out_ready_i,
        .rsp_in_valid_i, .rsp_in_i, .rsp_in_ready_o,
        .rd_rsp_valid_o, .rd_rsp_o, .rd_rsp_ready_i,
        .tag_hit_i     (tag_hit),
        .way_hit_i     (way_hit),
        .victim_way_i  (victim_way),
        .rd_tags_i     (rd_tags),
        .rd_states_i   (rd_states),
        .rd_lines_i    (rd_lines),
        .merged_line_i (merged_line),
        .merge_line_o  (merge_line),
        .merge_w_off_o (merge_w_off),
        .merge_b_off_o (merge_b_off),
        .merge_hsize_o (merge_hsize),
        .merge_word_o  (merge_word),
        .req_tag_o     (req_tag),
        .set_o         (set),
        .wr_en_o       (wr_en),
        .wr_way_o      (wr_way),
        .wr_tag_o      (wr_tag),
        .wr_state_o    (wr_state),
        .wr_line_o     (wr_line),
        .incr_evict_o  (incr_evict)
    );

    l2_lookup u_lookup (
        .req_tag_i    (req_tag),
        .tags_i       (rd_tags),
        .states_i     (rd_states),
        .evict_way_i  (evict_way),
        .tag_hit_o    (tag_hit),
        .way_hit_o    (way_hit),
        .victim_way_o (victim_way)
    );

    l2_localmem u_localmem (
        .clk, .rst_i,
        .set_i        (set),
        .wr_en_i      (wr_en),
        .wr_way_i     (wr_way),
        .wr_tag_i     (wr_tag),
        .wr_state_i   (wr_state),
        .wr_line_i    (wr_line),
        .incr_evict_i (incr_evict),
        .rd_tags_o    (rd_tags),
        .rd_states_o  (rd_states),
        .rd_lines_o   (rd_lines),
        .evict_way_o  (evict_way)
    );

    l2_write_word u_write_word (
        .line_i  (merge_line),
        .w_off_i (merge_w_off),
        .b_off_i (merge_b_off),
        .hsize_i (merge_hsize),
        .word_i  (merge_word),
        .line_o  (merged_line)
    );

endmodule

`default_nettype wire

/* test/l2_core_props.sv */
`default_nettype none

module l2_core_props (
    input wire logic                       clk,
    input wire logic                       rst_i,
    input wire logic                       cpu_req_ready_o,
    input wire logic                       req_out_valid_o,
    input wire cache_msg_pkg::l2_req_out_t req_out_o,
    input wire logic                       req_out_ready_i,
    input wire logic                       rsp_in_ready_o,
    input wire logic                       rd_rsp_valid_o,
    input wire cache_msg_pkg::l2_rd_rsp_t  rd_rsp_o,
    input wire logic                       rd_rsp_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_msg_pkg::*;

    req_out_hold: assert property (@(posedge clk) disable iff (rst_i)
        req_out_valid_o && !req_out_ready_i |=> req_out_valid_o && $stable(req_out_o))
        else $error("req_out dropped or changed before its transfer");

    rd_rsp_hold: assert property (@(posedge clk) disable iff (rst_i)
        rd_rsp_valid_o && !rd_rsp_ready_i |=> rd_rsp_valid_o && $stable(rd_rsp_o))
        else $error("rd_rsp dropped or changed before its transfer");

    // a writeback is always followed by the fill request
    put_then_get: assert property (@(posedge clk) disable iff (rst_i)
        req_out_valid_o && req_out_ready_i && req_out_o.coh_msg == PUT
        |=> req_out_valid_o && req_out_o.coh_msg == GET)
        else $error("writeback not followed by a fill request");

    reset_idle: assert property (@(posedge clk)
        rst_i |=> cpu_req_ready_o && !req_out_valid_o && !rsp_in_ready_o && !rd_rsp_valid_o)
        else $error("core not idle after reset");

endmodule

`default_nettype wire

/* test/l2_core_tb.sv */
`include "cache_config.svh"
`default_nettype none

module l2_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;
    import cache_msg_pkg::*;

    localparam int LIMIT = 200;

    logic        clk;
    logic        rst_i;
    logic        cpu_req_valid_i;
    l2_cpu_req_t cpu_req_i;
    logic        cpu_req_ready_o;
    logic        req_out_valid_o;
    l2_req_out_t req_out_o;
    logic        req_out_ready_i;
    logic        rsp_in_valid_i;
    l2_rsp_in_t  rsp_in_i;
    logic        rsp_in_ready_o;
    logic        rd_rsp_valid_o;
    l2_rd_rsp_t  rd_rsp_o;
    logic        rd_rsp_ready_i;

    int          errors;
    int          checks;
    logic [15:0] lfsr_q;
    logic        stall_en;

    // observed and predicted req_out transfers
    coh_msg_t    got_msg[$];
    line_addr_t  got_addr[$];
    line_t       got_line[$];
    coh_msg_t    exp_msg[$];
    line_addr_t  exp_addr[$];
    line_t       exp_line[$];

    line_t       wb_mem[line_addr_t];
    line_t       ref_mem[line_addr_t];
    l2_tag_t     ref_tag[`L2_SETS][`L2_WAYS];
    state_t      ref_state[`L2_SETS][`L2_WAYS];
    line_t       ref_line[`L2_SETS][`L2_WAYS];
    int          ref_ptr[`L2_SETS];

    l2_core u_l2_core (.*);

    bind l2_core l2_core_props u_props (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic line_t init_line(input line_addr_t la);
        line_t ln;
        for (int i = 0; i < `WORDS_PER_LINE; i++) begin
            ln[i*`WORD_BITS +: `WORD_BITS] = {la, i[1:0], 2'b00} ^ 32'h5a5a_0f0f;
        end
        return ln;
    endfunction

    function automatic line_t mem_read(input line_addr_t la);
        if (wb_mem.exists(la)) begin
            return wb_mem[la];
        end
        return init_line(la);
    endfunction

    function automatic line_t ref_mem_read(input line_addr_t la);
        if (ref_mem.exists(la)) begin
            return ref_mem[la];
        end
        return init_line(la);
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("checks=%0d errors=%0d", checks, errors + 1);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic mismatch(input string name, input logic [127:0] e, input logic [127:0] a);
        errors++;
        $display("Mismatch %s expected %h actual %h", name, e, a);
    endtask

    // randomized readies, full speed when stalls are off
    initial begin : ready_driver
        forever begin
            @(posedge clk);
            req_out_ready_i <= stall_en ? (rand_bits(2) != 0) : 1'b1;
            rd_rsp_ready_i  <= stall_en ? (rand_bits(2) != 0) : 1'b1;
        end
    end

    // memory side: logs req_out, stores PUTs, answers GETs
    initial begin : memory_responder
        int         t;
        int         dly;
        line_addr_t la;
        forever begin
            @(posedge clk);
            if (req_out_valid_o && req_out_ready_i) begin
                got_msg.push_back(req_out_o.coh_msg);
                got_addr.push_back(req_out_o.line_addr);
                got_line.push_back(req_out_o.line);
                la = req_out_o.line_addr;
                if (req_out_o.coh_msg == PUT) begin
                    wb_mem[la] = req_out_o.line;
                end else begin
                    dly = stall_en ? int'(rand_bits(3)) : 0;
                    repeat (dly) @(posedge clk);
                    rsp_in_valid_i <= 1'b1;
                    rsp_in_i       <= '{line_addr: la, line: mem_read(la)};
                    t = 0;
                    do begin
                        @(posedge clk);
                        t++;
                        if (t > LIMIT) abort_on_timeout("rsp_in ready");
                    end while (!rsp_in_ready_o);
                    rsp_in_valid_i <= 1'b0;
                end
            end
        end
    end

    // reference cache, predicts traffic and the read word
    task automatic model_access(input cpu_msg_t msg, input hsize_t hs, input addr_t a,
                                input word_t wd, output word_t rword);
        l2_addr_u ua;
        int       way;
        int       src;
        logic     take;
        line_t    ln;
        ua.addr = a;
        way     = -1;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (ref_state[ua.br.set][w] != INVALID && ref_tag[ua.br.set][w] == ua.br.tag) begin
                way = w;
            end
        end
        if (way < 0) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (ref_state[ua.br.set][w] == INVALID && way < 0) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way = ref_ptr[ua.br.set];
            end
            if (ref_state[ua.br.set][way] == DIRTY) begin
                exp_msg.push_back(PUT);
                exp_addr.push_back({ref_tag[ua.br.set][way], ua.br.set});
                exp_line.push_back(ref_line[ua.br.set][way]);
                ref_mem[{ref_tag[ua.br.set][way], ua.br.set}] = ref_line[ua.br.set][way];
            end
            exp_msg.push_back(GET);
            exp_addr.push_back({ua.br.tag, ua.br.set});
            exp_line.push_back('0);
            ref_tag[ua.br.set][way]   = ua.br.tag;
            ref_state[ua.br.set][way] = VALID;
            ref_line[ua.br.set][way]  = ref_mem_read({ua.br.tag, ua.br.set});
            ref_ptr[ua.br.set]        = (ref_ptr[ua.br.set] + 1) % `L2_WAYS;
        end
        ln = ref_line[ua.br.set][way];
        if (msg == WRITE) begin
            for (int b = 0; b < 4; b++) begin
                take = (hs == WORD) || (hs == HALF && (b / 2) == ua.br.b_off[1])
                       || (hs == BYTE && b == ua.br.b_off);
                src  = (hs == WORD) ? b : ((hs == HALF) ? b % 2 : 0);
                if (take) begin
                    ln[ua.br.w_off*`WORD_BITS + b*8 +: 8] = wd[src*8 +: 8];
                end
            end
            ref_line[ua.br.set][way]  = ln;
            ref_state[ua.br.set][way] = DIRTY;
        end
        rword = ln[ua.br.w_off*`WORD_BITS +: `WORD_BITS];
    endtask

    task automatic cpu_access(input cpu_msg_t msg, input hsize_t hs, input addr_t a,
                              input word_t wd, output word_t rdata, output int lat);
        int t;
        lat = -1;
        @(posedge clk);
        cpu_req_valid_i <= 1'b1;
        cpu_req_i       <= '{cpu_msg: msg, hsize: hs, addr: a, word: wd};
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > LIMIT) abort_on_timeout("cpu_req acceptance");
        end while (!cpu_req_ready_o);
        cpu_req_valid_i <= 1'b0;
        t = 0;
        rdata = '0;
        // lat counts edges after accept until the response is first seen
        do begin
            @(posedge clk);
            t++;
            if (t > LIMIT) abort_on_timeout("request completion");
            if (lat < 0 && (msg == READ ? rd_rsp_valid_o : cpu_req_ready_o)) lat = t;
        end while (msg == READ ? !(rd_rsp_valid_o && rd_rsp_ready_i) : !cpu_req_ready_o);
        if (msg == READ) begin
            rdata = rd_rsp_o.word;
        end
    endtask

    task automatic check_traffic(input string name, output int n_put);
        n_put = 0;
        checks++;
        if (got_msg.size() != exp_msg.size()) begin
            errors++;
            $display("%s: expected %0d req_out transfers, saw %0d", name,
                     exp_msg.size(), got_msg.size());
        end else begin
            foreach (got_msg[i]) begin
                if (got_msg[i] == PUT) n_put++;
                if (got_msg[i] != exp_msg[i]) mismatch(name, exp_msg[i], got_msg[i]);
                if (got_addr[i] != exp_addr[i]) mismatch(name, exp_addr[i], got_addr[i]);
                if (exp_msg[i] == PUT && got_line[i] != exp_line[i]) begin
                    mismatch(name, exp_line[i], got_line[i]);
                end
            end
        end
        got_msg.delete();
        got_addr.delete();
        got_line.delete();
        exp_msg.delete();
        exp_addr.delete();
        exp_line.delete();
    endtask

    task automatic access_check(input string name, input cpu_msg_t msg, input hsize_t hs,
                                input addr_t a, input word_t wd, output int lat, output int n_put);
        word_t exp_word;
        word_t got_word;
        model_access(msg, hs, a, wd, exp_word);
        cpu_access(msg, hs, a, wd, got_word, lat);
        if (msg == READ) begin
            checks++;
            if (got_word != exp_word) mismatch(name, exp_word, got_word);
        end
        check_traffic(name, n_put);
    endtask

    task automatic test_reset();
        int lat;
        int n_put;
        @(posedge clk);
        checks++;
        if (!cpu_req_ready_o || req_out_valid_o || rsp_in_ready_o || rd_rsp_valid_o) begin
            errors++;
            $display("reset: core handshakes not idle after reset");
        end
        access_check("reset_first_read", READ, WORD, 32'h0000_1234, '0, lat, n_put);
        checks++;
        if (n_put != 0) mismatch("reset_first_read", 0, n_put);
    endtask

    task automatic test_hit();
        int lat;
        int n_put;
        access_check("read_hit", READ, WORD, 32'h0000_1238, '0, lat, n_put);
        checks++;
        // valid rises after the second edge and is seen at the third
        if (lat != 3) mismatch("read_hit_latency", 3, lat);
    endtask

    task automatic test_subword();
        int lat;
        int n_put;
        access_check("byte_write", WRITE, BYTE, 32'h0000_1231, 32'h0000_00a7, lat, n_put);
        access_check("byte_read", READ, WORD, 32'h0000_1230, '0, lat, n_put);
        access_check("half_write", WRITE, HALF, 32'h0000_1236, 32'h0000_c3d2, lat, n_put);
        access_check("half_read", READ, WORD, 32'h0000_1234, '0, lat, n_put);
        access_check("word_write", WRITE, WORD, 32'h0000_1238, 32'h1357_9bdf, lat, n_put);
        access_check("word_read", READ, WORD, 32'h0000_1238, '0, lat, n_put);
        access_check("top_byte_write", WRITE, BYTE, 32'h0000_123f, 32'h0000_005e, lat, n_put);
        access_check("top_byte_read", READ, WORD, 32'h0000_123c, '0, lat, n_put);
    endtask

    task automatic test_evict();
        int lat;
        int n_put;
        access_check("evict_write_a", WRITE, WORD, 32'h0001_0050, 32'hdead_beef, lat, n_put);
        access_check("evict_read_b", READ, WORD, 32'h0002_0054, '0, lat, n_put);
        access_check("evict_read_c", READ, WORD, 32'h0003_0058, '0, lat, n_put);
        checks++;
        if (n_put != 1) mismatch("evict_dirty_put", 1, n_put);
        access_check("evict_read_d", READ, WORD, 32'h0004_005c, '0, lat, n_put);
        checks++;
        if (n_put != 0) mismatch("evict_clean_put", 0, n_put);
        // c must have survived the round-robin choice for d
        access_check("evict_reread_c", READ, WORD, 32'h0003_0058, '0, lat, n_put);
    endtask

    task automatic test_stall();
        int       lat;
        int       n_put;
        cpu_msg_t msg;
        hsize_t   hs;
        addr_t    a;
        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            msg = rand_bits(1) ? WRITE : READ;
            case (rand_bits(2))
                2'd0:    hs = BYTE;
                2'd1:    hs = HALF;
                default: hs = WORD;
            endcase
            a = {22'h0ab1, 2'(rand_bits(2)), 2'b00, 2'(rand_bits(2)),
                 2'(rand_bits(2)), 2'(rand_bits(2))};
            access_check("stall_random", msg, hs, a, rand_bits(32), lat, n_put);
        end
        stall_en = 1'b0;
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        lfsr_q          = 16'd28315;
        stall_en        = 1'b0;
        rst_i           = 1'b1;
        cpu_req_valid_i = 1'b0;
        cpu_req_i       = '0;
        req_out_ready_i = 1'b1;
        rsp_in_valid_i  = 1'b0;
        rsp_in_i        = '0;
        rd_rsp_ready_i  = 1'b1;
        for (int s = 0; s < `L2_SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                ref_state[s][w] = INVALID;
                ref_tag[s][w]   = '0;
                ref_line[s][w]  = '0;
            end
        end
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        test_reset();
        test_hit();
        test_subword();
        test_evict();
        test_stall();
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* l2_core.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_msg_pkg.sv
hdl/l2_lookup.sv
hdl/l2_localmem.sv
hdl/l2_write_word.sv
hdl/l2_fsm.sv
hdl/l2_core.sv
test/l2_core_props.sv
test/l2_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --assert --timing
TOP       ?= l2_core_tb
FILELIST  ?= l2_core.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
